// ==== sim/nkmd_cpu_props.sv ====
module nkmd_cpu_props (
    input logic            clk,
    input logic            rst,
    input nkmd_pkg::word_t p_addr_o,
    input nkmd_pkg::word_t p_data_i,
    input nkmd_pkg::word_t r_addr_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import nkmd_pkg::*;

    int run_cnt;
    int fail_cnt = 0;

    always @(posedge clk) begin
        if (rst) run_cnt <= 0;
        else if (run_cnt < 8) run_cnt <= run_cnt + 1;
    end

    first_fetch: assert property (@(posedge clk) $fell(rst) |-> p_addr_o == '0)
        else begin
            fail_cnt++;
            $error("p_addr_o is not zero after reset");
        end

    // Only a jump five fetches back breaks the count
    pc_step: assert property (@(posedge clk) disable iff (rst)
        run_cnt >= 5 && !$past(p_data_i[jmp_bit], 5) |-> p_addr_o == $past(p_addr_o) + 1)
        else begin
            fail_cnt++;
            $error("p_addr_o did not step by one");
        end

    imm_addr: assert property (@(posedge clk) disable iff (rst)
        run_cnt >= 2 && $past(p_data_i[imm_en_bit], 2) && !$past(p_data_i[jmp_bit], 2)
        |-> r_addr_o == {{17{$past(p_data_i[sign_bit], 2)}}, $past(p_data_i[14:0], 2)})
        else begin
            fail_cnt++;
            $error("r_addr_o is not the immediate");
        end

endmodule

bind nkmd_cpu nkmd_cpu_props nkmd_cpu_props_inst (.*);

// ==== sim/tb_nkmd_cpu.sv ====
module tb_nkmd_cpu;
    timeunit 1ns;
    timeprecision 1ps;
    import nkmd_pkg::*;

    localparam word_t r_key = 32'h5a5a_0f0f;
    localparam word_t c_off = 32'h1234_5678;

    logic  clk;
    logic  rst;
    word_t p_data, r_data, c_data, p_addr, r_addr, c_addr;
    word_t prog  [0:1023];
    word_t exp_p [0:4095];
    word_t exp_r [0:4095];
    word_t exp_c [0:4095];
    word_t regs  [0:15];
    int    plen, n_fetch, cyc, errors;
    int    test_addr [0:4];
    int    test_end  [0:5];
    regsel_t wr [0:12] = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 12, 13, 14};
    string test_name [0:5] = '{"reset and fetch", "immediate alu", "register t operand",
                               "bus reads", "jumps", "random programs"};

    nkmd_cpu nkmd_cpu_inst (
        .clk(clk), .rst(rst),
        .p_data_i(p_data), .r_data_i(r_data), .c_data_i(c_data),
        .p_addr_o(p_addr), .r_addr_o(r_addr), .c_addr_o(c_addr)
    );

    // Memories answer in the same cycle
    assign p_data = (p_addr < 1024) ? prog[p_addr[9:0]] : '0;
    assign r_data = r_addr ^ r_key;
    assign c_data = c_addr + c_off;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) cyc <= 0;
        else     cyc <= cyc + 1;
    end

    fetch_chk: assert property (@(posedge clk) disable iff (rst)
        cyc < n_fetch |-> p_addr == exp_p[cyc])
        else begin
            errors++;
            $display("mismatch at %0t: p_addr_o %h, expected %h", $time,
                     $sampled(p_addr), exp_p[$sampled(cyc)]);
        end
    raddr_chk: assert property (@(posedge clk) disable iff (rst)
        cyc >= 2 && cyc < n_fetch + 2 |-> r_addr == exp_r[cyc-2])
        else begin
            errors++;
            $display("mismatch at %0t: r_addr_o %h, expected %h", $time,
                     $sampled(r_addr), exp_r[$sampled(cyc)-2]);
        end
    caddr_chk: assert property (@(posedge clk) disable iff (rst)
        cyc >= 2 && cyc < n_fetch + 2 |-> c_addr == exp_c[cyc-2])
        else begin
            errors++;
            $display("mismatch at %0t: c_addr_o %h, expected %h", $time,
                     $sampled(c_addr), exp_c[$sampled(cyc)-2]);
        end

    function automatic word_t xorshift(word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic word_t alu_inst(alusel_t op, regsel_t rd, regsel_t rs, logic imm_en,
                                       logic tread, logic [15:0] low);
        word_t w;
        w = '0;
        w[tread_bit] = tread;
        w[rd_lsb +: 4] = rd;
        w[alu_lsb +: 3] = op;
        w[rs_lsb +: 4] = rs;
        w[imm_en_bit] = imm_en;
        w[15:0] = low;
        return w;
    endfunction

    function automatic word_t reg_inst(alusel_t op, regsel_t rd, regsel_t rs, regsel_t rt,
                                       logic tread, logic cread);
        return alu_inst(op, rd, rs, 1'b0, tread, {4'h0, rt, 7'h0, cread});
    endfunction

    function automatic word_t jump_inst(regsel_t rd, logic [7:0] rel);
        word_t w;
        w = alu_inst(op_add, rd, reg_zero, 1'b0, 1'b0, {{8{rel[7]}}, rel});
        w[jmp_bit] = 1'b1;
        return w;
    endfunction

    task automatic emit(word_t w, int pad);
        prog[plen] = w;
        plen += 1 + pad;
    endtask

    task automatic load_imm(regsel_t rd, int val);
        emit(alu_inst(op_add, rd, reg_zero, 1'b1, 1'b0, 16'(val)), 3);
    endtask

    // rs shows on c_addr_o and rt on r_addr_o
    task automatic read_back(regsel_t r);
        emit(reg_inst(op_add, reg_zero, r, r, 1'b0, 1'b0), 3);
    endtask

    function automatic word_t reg_val(logic [3:0] s);
        return (s == 0 || s == 11 || s == 15) ? '0 : regs[s];
    endfunction

    task automatic run_model();
        int    pc, pend, ti;
        word_t w, ra, ca, s, t, res, tgt;
        pc = 0;
        pend = 0;
        ti = 0;
        n_fetch = 0;
        foreach (regs[i]) regs[i] = '0;
        while ((pc < plen || pend > 0) && n_fetch < 4096) begin
            if (ti < 5 && pc == test_addr[ti]) begin
                test_end[ti] = n_fetch;
                ti++;
            end
            w = prog[pc];
            exp_p[n_fetch] = pc;
            ra = w[16] ? {{17{w[15]}}, w[14:0]} : reg_val(w[11:8]);
            ca = reg_val(w[20:17]);
            exp_r[n_fetch] = ra;
            exp_c[n_fetch] = ca;
            if (w[31]) begin
                pend = 5;
                tgt = reg_val(w[27:24]) + {{24{w[15]}}, w[7:0]};
            end else begin
                t = w[28] ? (ra ^ r_key) : ra;
                s = (w[0] && !w[16]) ? (ca + c_off) : ca;
                case (w[23:21])
                    3'd0: res = s + t;
                    3'd1: res = s - t;
                    3'd2: res = s | t;
                    3'd3: res = s & t;
                    3'd4: res = s ^ t;
                    default: res = '0;
                endcase
                if (w[27:24] != 0 && w[27:24] != 11 && w[27:24] != 15) regs[w[27:24]] = res;
            end
            n_fetch++;
            if (pend > 0) begin
                pend--;
                pc = (pend == 0) ? int'(tgt) : pc + 1;
            end else begin
                pc++;
            end
        end
        test_end[5] = n_fetch;
    endtask

    task automatic build_program();
        word_t rnd;
        int    j;
        rnd = 32'd58119;
        emit('0, 7);
        test_addr[0] = plen;
        foreach (wr[i]) load_imm(wr[i], (i % 2) ? -(i * 37 + 1) : i * 1000 + 5);
        foreach (wr[i]) read_back(wr[i]);
        for (int op = 1; op < 8; op++) begin
            emit(alu_inst(alusel_t'(op), regsel_t'(op), reg_n, 1'b1, 1'b0,
                          16'h7a5c ^ 16'(op)), 3);
        end
        for (int r = 1; r < 8; r++) read_back(regsel_t'(r));
        test_addr[1] = plen;
        emit(reg_inst(op_add, 2, 3, 4, 1'b0, 1'b0), 3);
        emit(reg_inst(op_add, 5, 3, reg_zero, 1'b0, 1'b0), 3);
        load_imm(reg_ra, 99);
        load_imm(reg_pc, 99);
        load_imm(reg_zero, 99);
        emit(reg_inst(op_or, 6, 3, reg_ra, 1'b0, 1'b0), 3);
        emit(reg_inst(op_add, 7, reg_pc, reg_pc, 1'b0, 1'b0), 3);
        foreach (wr[i]) read_back(wr[i]);
        read_back(reg_ra);
        test_addr[2] = plen;
        emit(alu_inst(op_add, 9, 1, 1'b1, 1'b1, 16'h0123), 3);
        emit(reg_inst(op_sub, 10, 2, 3, 1'b1, 1'b1), 3);
        read_back(9);
        read_back(10);
        test_addr[3] = plen;
        // Jump at j goes to j+20, back to j+5, then on to j+40
        j = plen + 8;
        load_imm(1, j);
        load_imm(5, j + 30);
        emit(jump_inst(1, 8'd20), 4);
        load_imm(3, 77);
        emit(jump_inst(1, 8'd40), 4);
        plen = j + 20;
        load_imm(4, 5);
        emit(jump_inst(5, -8'sd25), 4);
        plen = j + 40;
        read_back(1);
        read_back(3);
        read_back(4);
        test_addr[4] = plen;
        repeat (40) begin
            rnd = xorshift(rnd);
            emit(alu_inst(rnd[2:0], rnd[7:4], rnd[11:8], rnd[12], rnd[13], rnd[31:16]), 3);
        end
        foreach (wr[i]) read_back(wr[i]);
    endtask

    initial begin
        int cycles, limit, ti, prev, total;
        rst = 1'b1;
        errors = 0;
        plen = 0;
        n_fetch = 0;
        foreach (prog[i]) prog[i] = '0;
        build_program();
        run_model();
        limit = 4 * plen + 50;
        cycles = 0;
        ti = 0;
        prev = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        while (ti < 6 && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cyc >= test_end[ti] + 2) begin
                $display("test %0d %s: %0d errors", ti + 1, test_name[ti], errors - prev);
                prev = errors;
                ti++;
            end
        end
        total = errors + nkmd_cpu_inst.nkmd_cpu_props_inst.fail_cnt;
        $display("tests finished: %0d of 6, errors: %0d", ti, total);
        if (ti < 6) begin
            $display("timeout: the run stopped after %0d cycles without finishing", cycles);
            $display("Simulation failed");
        end else if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== source/nkmd_cpu.sv ====
module nkmd_cpu (
    input  logic            clk,
    input  logic            rst,
    input  nkmd_pkg::word_t p_data_i,
    input  nkmd_pkg::word_t r_data_i,
    input  nkmd_pkg::word_t c_data_i,
    output nkmd_pkg::word_t p_addr_o,
    output nkmd_pkg::word_t r_addr_o,
    output nkmd_pkg::word_t c_addr_o
);
    import nkmd_pkg::*;

    // Decode outputs
    regsel_t dcd_rssel;
    regsel_t dcd_rtsel;
    regsel_t dcd_rdsel;
    alusel_t dcd_alusel;
    word_t   dcd_imm;
    word_t   dcd_jmprel;
    logic    dcd_imm_en;
    logic    dcd_jmp_en;
    logic    dcd_r_read_en;
    logic    dcd_c_read_en;

    // Register file reads
    word_t   rf_rsval;
    word_t   rf_rtval;
    word_t   rf_rdval;

    // Operand stage to execute
    word_t   opd_sval;
    word_t   opd_tval;
    word_t   opd_rdval;
    word_t   opd_jmprel;
    alusel_t opd_alusel;
    regsel_t opd_rdsel;
    logic    opd_jmp_en;

    // Execute results
    regsel_t ex_wb_sel;
    word_t   ex_wb_val;
    logic    ex_jmp_en;
    word_t   ex_jmp_pc;

    nkmd_fetch nkmd_fetch_inst (
        .clk(clk), .rst(rst),
        .jmp_en_i(ex_jmp_en),
        .jmp_pc_i(ex_jmp_pc),
        .pc_o(p_addr_o)
    );

    // Program bus answers in the same cycle
    nkmd_decode nkmd_decode_inst (
        .clk(clk),
        .inst_i(p_data_i),
        .rssel_o(dcd_rssel), .rtsel_o(dcd_rtsel), .rdsel_o(dcd_rdsel),
        .alusel_o(dcd_alusel),
        .imm_o(dcd_imm), .jmprel_o(dcd_jmprel),
        .imm_en_o(dcd_imm_en), .jmp_en_o(dcd_jmp_en),
        .r_read_en_o(dcd_r_read_en), .c_read_en_o(dcd_c_read_en)
    );

    nkmd_regfile nkmd_regfile_inst (
        .clk(clk), .rst(rst),
        .rssel_i(dcd_rssel), .rtsel_i(dcd_rtsel), .rdsel_i(dcd_rdsel),
        .wb_sel_i(ex_wb_sel), .wb_val_i(ex_wb_val),
        .rsval_o(rf_rsval), .rtval_o(rf_rtval), .rdval_o(rf_rdval)
    );

    nkmd_operand nkmd_operand_inst (
        .clk(clk), .rst(rst),
        .rsval_i(rf_rsval), .rtval_i(rf_rtval), .rdval_i(rf_rdval),
        .imm_i(dcd_imm), .jmprel_i(dcd_jmprel),
        .imm_en_i(dcd_imm_en),
        .r_read_en_i(dcd_r_read_en), .c_read_en_i(dcd_c_read_en),
        .jmp_en_i(dcd_jmp_en),
        .alusel_i(dcd_alusel), .rdsel_i(dcd_rdsel),
        .r_data_i(r_data_i), .c_data_i(c_data_i),
        .r_addr_o(r_addr_o), .c_addr_o(c_addr_o),
        .sval_o(opd_sval), .tval_o(opd_tval), .rdval_o(opd_rdval),
        .jmprel_o(opd_jmprel), .alusel_o(opd_alusel),
        .rdsel_o(opd_rdsel), .jmp_en_o(opd_jmp_en)
    );

    nkmd_execute nkmd_execute_inst (
        .clk(clk), .rst(rst),
        .sval_i(opd_sval), .tval_i(opd_tval), .rdval_i(opd_rdval),
        .jmprel_i(opd_jmprel), .alusel_i(opd_alusel),
        .rdsel_i(opd_rdsel), .jmp_en_i(opd_jmp_en),
        .wb_sel_o(ex_wb_sel), .wb_val_o(ex_wb_val),
        .jmp_en_o(ex_jmp_en), .jmp_pc_o(ex_jmp_pc)
    );

endmodule

// ==== source/nkmd_decode.sv ====
module nkmd_decode (
    input  logic              clk,
    input  nkmd_pkg::word_t   inst_i,
    output nkmd_pkg::regsel_t rssel_o,
    output nkmd_pkg::regsel_t rtsel_o,
    output nkmd_pkg::regsel_t rdsel_o,
    output nkmd_pkg::alusel_t alusel_o,
    output nkmd_pkg::word_t   imm_o,
    output nkmd_pkg::word_t   jmprel_o,
    output logic              imm_en_o,
    output logic              jmp_en_o,
    output logic              r_read_en_o,
    output logic              c_read_en_o
);
    import nkmd_pkg::*;

    logic is_jmp;
    logic use_imm;

    assign is_jmp  = inst_i[jmp_bit];
    assign use_imm = inst_i[imm_en_bit];

    always_ff @(posedge clk) begin
        rssel_o  <= inst_i[rs_lsb +: regsel_w];
        rtsel_o  <= inst_i[rt_lsb +: regsel_w];
        rdsel_o  <= inst_i[rd_lsb +: regsel_w];
        alusel_o <= inst_i[alu_lsb +: alusel_w];

        // Both fields share the one sign bit
        imm_o    <= {{(word_w - imm_w){inst_i[sign_bit]}}, inst_i[imm_w-1:0]};
        jmprel_o <= {{(word_w - jmprel_w){inst_i[sign_bit]}}, inst_i[jmprel_w-1:0]};

        imm_en_o <= use_imm;
        jmp_en_o <= is_jmp;

        // Jumps never touch the buses
        r_read_en_o <= !is_jmp && inst_i[tread_bit];
        c_read_en_o <= !is_jmp && !use_imm && inst_i[cread_bit];
    end

endmodule

// ==== source/nkmd_execute.sv ====
module nkmd_execute (
    input  logic              clk,
    input  logic              rst,
    input  nkmd_pkg::word_t   sval_i,
    input  nkmd_pkg::word_t   tval_i,
    input  nkmd_pkg::word_t   rdval_i,
    input  nkmd_pkg::word_t   jmprel_i,
    input  nkmd_pkg::alusel_t alusel_i,
    input  nkmd_pkg::regsel_t rdsel_i,
    input  logic              jmp_en_i,
    output nkmd_pkg::regsel_t wb_sel_o,
    output nkmd_pkg::word_t   wb_val_o,
    output logic              jmp_en_o,
    output nkmd_pkg::word_t   jmp_pc_o
);
    import nkmd_pkg::*;

    word_t alu_res;

    always_comb begin
        case (alusel_i)
            op_add:           alu_res = sval_i + tval_i;
            op_sub:           alu_res = sval_i - tval_i;
            op_or:            alu_res = sval_i | tval_i;
            op_and:           alu_res = sval_i & tval_i;
            op_xor:           alu_res = sval_i ^ tval_i;
            // Clamp and mul yield zero like the reserved code
            op_clamp, op_mul: alu_res = '0;
            default:          alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        wb_val_o <= alu_res;
        jmp_pc_o <= rdval_i + jmprel_i;
        if (rst) begin
            wb_sel_o <= reg_zero;
            jmp_en_o <= 1'b0;
        end else begin
            // Jumps leave the register file alone
            wb_sel_o <= jmp_en_i ? reg_zero : rdsel_i;
            jmp_en_o <= jmp_en_i;
        end
    end

endmodule

// ==== source/nkmd_fetch.sv ====
module nkmd_fetch (
    input  logic            clk,
    input  logic            rst,
    input  logic            jmp_en_i,
    input  nkmd_pkg::word_t jmp_pc_i,
    output nkmd_pkg::word_t pc_o
);

    // Target is fetched once the four delay slots have gone
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_o <= '0;
        end else if (jmp_en_i) begin
            pc_o <= jmp_pc_i;
        end else begin
            pc_o <= pc_o + 1'b1;
        end
    end

endmodule

// ==== source/nkmd_operand.sv ====
module nkmd_operand (
    input  logic              clk,
    input  logic              rst,
    input  nkmd_pkg::word_t   rsval_i,
    input  nkmd_pkg::word_t   rtval_i,
    input  nkmd_pkg::word_t   rdval_i,
    input  nkmd_pkg::word_t   imm_i,
    input  nkmd_pkg::word_t   jmprel_i,
    input  logic              imm_en_i,
    input  logic              r_read_en_i,
    input  logic              c_read_en_i,
    input  logic              jmp_en_i,
    input  nkmd_pkg::alusel_t alusel_i,
    input  nkmd_pkg::regsel_t rdsel_i,
    input  nkmd_pkg::word_t   r_data_i,
    input  nkmd_pkg::word_t   c_data_i,
    output nkmd_pkg::word_t   r_addr_o,
    output nkmd_pkg::word_t   c_addr_o,
    output nkmd_pkg::word_t   sval_o,
    output nkmd_pkg::word_t   tval_o,
    output nkmd_pkg::word_t   rdval_o,
    output nkmd_pkg::word_t   jmprel_o,
    output nkmd_pkg::alusel_t alusel_o,
    output nkmd_pkg::regsel_t rdsel_o,
    output logic              jmp_en_o
);
    import nkmd_pkg::*;

    // Decode fields held one cycle to line up with the regfile reads
    word_t   imm_ff;
    word_t   jmprel_ff;
    logic    imm_en_ff;
    logic    r_read_en_ff;
    logic    c_read_en_ff;
    logic    jmp_en_ff;
    alusel_t alusel_ff;
    regsel_t rdsel_ff;

    always_ff @(posedge clk) begin
        imm_ff       <= imm_i;
        jmprel_ff    <= jmprel_i;
        imm_en_ff    <= imm_en_i;
        r_read_en_ff <= r_read_en_i;
        c_read_en_ff <= c_read_en_i;
        alusel_ff    <= alusel_i;
        if (rst) begin
            jmp_en_ff <= 1'b0;
            rdsel_ff  <= reg_zero;
        end else begin
            jmp_en_ff <= jmp_en_i;
            rdsel_ff  <= rdsel_i;
        end
    end

    assign r_addr_o = imm_en_ff ? imm_ff : rtval_i;
    assign c_addr_o = rsval_i;

    // Without a bus read the address itself is the operand
    always_ff @(posedge clk) begin
        tval_o   <= r_read_en_ff ? r_data_i : r_addr_o;
        sval_o   <= c_read_en_ff ? c_data_i : rsval_i;
        rdval_o  <= rdval_i;
        jmprel_o <= jmprel_ff;
        alusel_o <= alusel_ff;
        if (rst) begin
            jmp_en_o <= 1'b0;
            rdsel_o  <= reg_zero;
        end else begin
            jmp_en_o <= jmp_en_ff;
            rdsel_o  <= rdsel_ff;
        end
    end

endmodule

// ==== source/nkmd_pkg.sv ====
package nkmd_pkg;

    localparam int word_w   = 32;
    localparam int regsel_w = 4;
    localparam int alusel_w = 3;

    typedef logic [word_w-1:0]   word_t;
    typedef logic [regsel_w-1:0] regsel_t;
    typedef logic [alusel_w-1:0] alusel_t;

    // Instruction word layout
    localparam int jmp_bit    = 31;
    localparam int tread_bit  = 28;
    localparam int rd_lsb     = 24;
    localparam int alu_lsb    = 21;
    localparam int rs_lsb     = 17;
    localparam int imm_en_bit = 16;
    localparam int sign_bit   = 15;
    localparam int imm_w      = 15;
    localparam int rt_lsb     = 8;
    localparam int jmprel_w   = 8;
    localparam int cread_bit  = 0;

    // ALU codes with 5 left reserved
    localparam alusel_t op_add   = 3'd0;
    localparam alusel_t op_sub   = 3'd1;
    localparam alusel_t op_or    = 3'd2;
    localparam alusel_t op_and   = 3'd3;
    localparam alusel_t op_xor   = 3'd4;
    localparam alusel_t op_clamp = 3'd6;
    localparam alusel_t op_mul   = 3'd7;

    // Selectors that are not plain registers, plus n at the top of the file
    localparam regsel_t reg_zero = 4'd0;
    localparam regsel_t reg_ra   = 4'd11;
    localparam regsel_t reg_n    = 4'd14;
    localparam regsel_t reg_pc   = 4'd15;

endpackage

// ==== source/nkmd_regfile.sv ====
module nkmd_regfile (
    input  logic              clk,
    input  logic              rst,
    input  nkmd_pkg::regsel_t rssel_i,
    input  nkmd_pkg::regsel_t rtsel_i,
    input  nkmd_pkg::regsel_t rdsel_i,
    input  nkmd_pkg::regsel_t wb_sel_i,
    input  nkmd_pkg::word_t   wb_val_i,
    output nkmd_pkg::word_t   rsval_o,
    output nkmd_pkg::word_t   rtval_o,
    output nkmd_pkg::word_t   rdval_o
);
    import nkmd_pkg::*;

    // a to j at 1..10, sl and sh at 12 and 13, n last
    word_t regs [1:reg_n];

    function automatic logic is_gpr(regsel_t sel);
        return (sel != reg_zero) && (sel != reg_ra) && (sel != reg_pc);
    endfunction

    function automatic word_t read_reg(regsel_t sel);
        word_t val;
        val = '0;
        if (is_gpr(sel)) begin
            val = regs[sel];
        end
        return val;
    endfunction

    // Only the general registers take a write
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= reg_n; i++) begin
                regs[i] <= '0;
            end
        end else if (is_gpr(wb_sel_i)) begin
            regs[wb_sel_i] <= wb_val_i;
        end
    end

    // Registered reads miss a write on the same edge
    always_ff @(posedge clk) begin
        rsval_o <= read_reg(rssel_i);
        rtval_o <= read_reg(rtsel_i);
        rdval_o <= read_reg(rdsel_i);
    end

endmodule

// ==== vlog.f ====
source/nkmd_pkg.sv
source/nkmd_fetch.sv
source/nkmd_decode.sv
source/nkmd_regfile.sv
source/nkmd_operand.sv
source/nkmd_execute.sv
source/nkmd_cpu.sv
sim/nkmd_cpu_props.sv
sim/tb_nkmd_cpu.sv
